// File: include/egr_params.svh
`ifndef EGR_PARAMS_SVH
`define EGR_PARAMS_SVH

// ####################################################################
// Egress datapath sizing
// ####################################################################

// Egress ports, each with a network and a host source
`define EGR_NUM_PORTS     2
// Bytes per stream beat
`define EGR_DATA_BYTES    8
// Stream sideband widths
`define EGR_TID_WID       4
`define EGR_TDEST_WID     4
`define EGR_TUSER_WID     8

// ####################################################################
// Register map
// ####################################################################

`define EGR_REG_ADDR_WID  8
// Arbitration mode, one bit per port
`define EGR_REG_CTRL      8'h00
// Packet counters, word per port and source, index 2*port+src
`define EGR_REG_CNT_BASE  8'h10

`endif

// File: logic/egr_pkg.sv
`include "egr_params.svh"

package egr_pkg;

    // ####################################################################
    // Stream beat
    // ####################################################################

    // One AXI4-Stream transfer, valid and ready travel separately
    typedef struct packed {
        logic [`EGR_DATA_BYTES*8-1:0] tdata;
        logic [`EGR_DATA_BYTES-1:0]   tkeep;
        logic                         tlast;
        logic [`EGR_TID_WID-1:0]      tid;
        logic [`EGR_TDEST_WID-1:0]    tdest;
        logic [`EGR_TUSER_WID-1:0]    tuser;
    } axis_beat_t;

    // Mux input index, also counter index within a port
    typedef enum logic {
        SRC_NET = 1'b0,
        SRC_H2C = 1'b1
    } egr_src_e;

    // Pulse per packet leaving the mux
    typedef struct packed {
        logic     done;
        egr_src_e src;
    } pkt_event_t;

    // ####################################################################
    // Register port
    // ####################################################################

    // Single-cycle strobes
    typedef struct packed {
        logic                         wr;
        logic                         rd;
        logic [`EGR_REG_ADDR_WID-1:0] addr;
        logic [31:0]                  wdata;
    } reg_req_t;

    // Read data one cycle after rd
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } reg_rsp_t;

endpackage

// File: logic/axis_stage.sv
`timescale 1ns/10ps
`include "egr_params.svh"

module axis_stage (
    input  logic                core_clk,
    input  logic                rst_n,

    // Upstream side
    input  egr_pkg::axis_beat_t in_beat,
    input  logic                in_valid,
    output logic                in_ready,

    // Downstream side
    output egr_pkg::axis_beat_t out_beat,
    output logic                out_valid,
    input  logic                out_ready
);

    // Held beat present
    logic full;

    // Take a beat when empty or when the held one leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;

    // ####################################################################
    // Occupancy
    // ####################################################################

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            // Refill or drain
            full <= in_valid;
        end
    end

    // ####################################################################
    // Payload
    // ####################################################################

    // No reset on data, qualified by full
    always_ff @(posedge core_clk) begin
        if (in_valid && in_ready) begin
            out_beat <= in_beat;
        end
    end

endmodule

// File: logic/axis_skid_stage.sv
`timescale 1ns/10ps
`include "egr_params.svh"

module axis_skid_stage (
    input  logic                core_clk,
    input  logic                rst_n,

    // Upstream side, ready straight from a flop
    input  egr_pkg::axis_beat_t in_beat,
    input  logic                in_valid,
    output logic                in_ready,

    // Downstream side
    output egr_pkg::axis_beat_t out_beat,
    output logic                out_valid,
    input  logic                out_ready
);

    import egr_pkg::*;

    // Main entry drives the output
    logic       main_vld;
    // Skid entry catches the beat in flight when the output stalls
    logic       skid_vld;
    axis_beat_t skid_beat;

    // Registered ready, high while skid entry is free
    assign in_ready  = !skid_vld;
    assign out_valid = main_vld;

    // ####################################################################
    // Entry state
    // ####################################################################

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            main_vld <= 1'b0;
            skid_vld <= 1'b0;
        end else if (skid_vld) begin
            // Input blocked, skid moves to main on a drain
            // Main stays valid either way
            if (out_ready) begin
                skid_vld <= 1'b0;
            end
        end else if (!main_vld || out_ready) begin
            // Main free or draining, load straight from input
            main_vld <= in_valid;
        end else if (in_valid) begin
            // Main stalled, park the incoming beat
            skid_vld <= 1'b1;
        end
    end

    // ####################################################################
    // Payload
    // ####################################################################

    // Same decisions as above, keeps arrival order
    always_ff @(posedge core_clk) begin
        if (skid_vld) begin
            if (out_ready) begin
                out_beat <= skid_beat;
            end
        end else if (!main_vld || out_ready) begin
            if (in_valid) begin
                out_beat <= in_beat;
            end
        end else if (in_valid) begin
            skid_beat <= in_beat;
        end
    end

endmodule

// File: logic/axis_pkt_mux.sv
`timescale 1ns/10ps
`include "egr_params.svh"

module axis_pkt_mux (
    input  logic                core_clk,
    input  logic                rst_n,

    // 0 round-robin, 1 network strict priority
    input  logic                mode,

    // Index 0 network, index 1 host
    input  egr_pkg::axis_beat_t in_beat  [2],
    input  logic [1:0]          in_valid,
    output logic [1:0]          in_ready,

    output egr_pkg::axis_beat_t out_beat,
    output logic                out_valid,
    input  logic                out_ready,

    // Registered pulse per finished packet
    output egr_pkg::pkt_event_t pkt_event
);

    import egr_pkg::*;

    // Grant held mid-packet or while a beat waits on ready
    logic     locked;
    egr_src_e grant_q;
    // Source of the last finished packet
    egr_src_e last_src;

    // Fresh pick and effective select
    egr_src_e pick;
    egr_src_e sel;

    logic out_xfer;
    logic pkt_end;

    // ####################################################################
    // Arbitration
    // ####################################################################

    always_comb begin
        if (in_valid == 2'b11) begin
            if (mode) begin
                // Strict, network always first
                pick = SRC_NET;
            end else begin
                // Round-robin, whichever was not served last
                pick = (last_src == SRC_NET) ? SRC_H2C : SRC_NET;
            end
        end else if (in_valid[SRC_H2C]) begin
            pick = SRC_H2C;
        end else begin
            // Network or idle
            pick = SRC_NET;
        end
    end

    assign sel = locked ? grant_q : pick;

    // ####################################################################
    // Data select
    // ####################################################################

    assign out_beat  = in_beat[sel];
    assign out_valid = in_valid[sel];

    // Only the granted side sees ready
    always_comb begin
        in_ready      = 2'b00;
        in_ready[sel] = out_ready;
    end

    assign out_xfer = out_valid && out_ready;
    assign pkt_end  = out_xfer && out_beat.tlast;

    // ####################################################################
    // Grant lock and packet events
    // ####################################################################

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            locked    <= 1'b0;
            grant_q   <= SRC_NET;
            // Host counts as last so network goes first
            last_src  <= SRC_H2C;
            pkt_event <= '0;
        end else begin
            pkt_event.done <= pkt_end;
            pkt_event.src  <= sel;
            // Presented beat pins the grant until tlast leaves
            if (out_valid) begin
                locked  <= !pkt_end;
                grant_q <= sel;
            end
            if (pkt_end) begin
                last_src <= sel;
            end
        end
    end

endmodule

// File: logic/egr_reg_blk.sv
`timescale 1ns/10ps
`include "egr_params.svh"

module egr_reg_blk #(
    parameter int NUM_PORTS = `EGR_NUM_PORTS
) (
    input  logic                core_clk,
    input  logic                rst_n,

    // Register strobe port
    input  egr_pkg::reg_req_t   reg_req,
    output egr_pkg::reg_rsp_t   reg_rsp,

    // Per-port packet pulses from the muxes
    input  egr_pkg::pkt_event_t pkt_event [NUM_PORTS],

    // Arbitration mode per port
    output logic [NUM_PORTS-1:0] mode
);

    import egr_pkg::*;

    localparam int ADDR_WID = `EGR_REG_ADDR_WID;
    // Network and host counter per port
    localparam int NUM_CNT  = 2 * NUM_PORTS;

    logic [NUM_PORTS-1:0] ctrl_q;
    logic [31:0]          cnt [NUM_CNT];

    logic [31:0] rd_data;
    logic        rsp_vld;
    logic [31:0] rsp_data;

    // ####################################################################
    // Control register
    // ####################################################################

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (reg_req.wr && reg_req.addr == `EGR_REG_CTRL) begin
            // Low bits only
            ctrl_q <= reg_req.wdata[NUM_PORTS-1:0];
        end
    end

    assign mode = ctrl_q;

    // ####################################################################
    // Packet counters
    // ####################################################################

    for (genvar c = 0; c < NUM_CNT; c++) begin : g_cnt
        localparam logic [ADDR_WID-1:0] CNT_ADDR = ADDR_WID'(`EGR_REG_CNT_BASE + 4 * c);

        logic inc;

        // Counter c tracks port c/2, source c%2
        assign inc = pkt_event[c / 2].done && (pkt_event[c / 2].src == egr_src_e'(c % 2));

        always_ff @(posedge core_clk or negedge rst_n) begin
            if (!rst_n) begin
                cnt[c] <= '0;
            end else if (reg_req.wr && reg_req.addr == CNT_ADDR) begin
                // Clear beats a same-cycle increment
                cnt[c] <= '0;
            end else if (inc) begin
                // Wraps
                cnt[c] <= cnt[c] + 32'd1;
            end
        end
    end

    // ####################################################################
    // Read-back
    // ####################################################################

    // Unmapped addresses fall through to zero
    always_comb begin
        rd_data = '0;
        if (reg_req.addr == `EGR_REG_CTRL) begin
            rd_data = 32'(ctrl_q);
        end
        for (int i = 0; i < NUM_CNT; i++) begin
            if (reg_req.addr == ADDR_WID'(`EGR_REG_CNT_BASE + 4 * i)) begin
                rd_data = cnt[i];
            end
        end
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= reg_req.rd;
        end
    end

    // Data only meaningful with rvalid
    always_ff @(posedge core_clk) begin
        if (reg_req.rd) begin
            rsp_data <= rd_data;
        end
    end

    assign reg_rsp = '{rvalid: rsp_vld, rdata: rsp_data};

endmodule

// File: logic/smartnic_egr.sv
`timescale 1ns/10ps
`include "egr_params.svh"

module smartnic_egr #(
    parameter int NUM_PORTS = `EGR_NUM_PORTS
) (
    input  logic                 core_clk,
    input  logic                 rst_n,

    // Application pipeline packets
    input  egr_pkg::axis_beat_t  net_beat  [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] net_valid,
    output logic [NUM_PORTS-1:0] net_ready,

    // Host-to-card packets
    input  egr_pkg::axis_beat_t  h2c_beat  [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] h2c_valid,
    output logic [NUM_PORTS-1:0] h2c_ready,

    // Egress ports
    output egr_pkg::axis_beat_t  out_beat  [NUM_PORTS],
    output logic [NUM_PORTS-1:0] out_valid,
    input  logic [NUM_PORTS-1:0] out_ready,

    input  egr_pkg::reg_req_t    reg_req,
    output egr_pkg::reg_rsp_t    reg_rsp
);

    import egr_pkg::*;

    pkt_event_t           pkt_event [NUM_PORTS];
    logic [NUM_PORTS-1:0] mode;

    // ####################################################################
    // Egress lanes
    // ####################################################################

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // Mux inputs, index 0 network, 1 host
        axis_beat_t mux_in_beat [2];
        logic [1:0] mux_in_valid;
        logic [1:0] mux_in_ready;

        // Mux to skid stage
        axis_beat_t mux_out_beat;
        logic       mux_out_valid;
        logic       mux_out_ready;

        axis_stage u_net_stage (
            .core_clk, .rst_n,
            .in_beat   (net_beat[p]),      .in_valid  (net_valid[p]),
            .in_ready  (net_ready[p]),     .out_beat  (mux_in_beat[SRC_NET]),
            .out_valid (mux_in_valid[SRC_NET]), .out_ready (mux_in_ready[SRC_NET])
        );

        axis_stage u_h2c_stage (
            .core_clk, .rst_n,
            .in_beat   (h2c_beat[p]),      .in_valid  (h2c_valid[p]),
            .in_ready  (h2c_ready[p]),     .out_beat  (mux_in_beat[SRC_H2C]),
            .out_valid (mux_in_valid[SRC_H2C]), .out_ready (mux_in_ready[SRC_H2C])
        );

        axis_pkt_mux u_mux (
            .core_clk, .rst_n,
            .mode      (mode[p]),
            .in_beat   (mux_in_beat),      .in_valid  (mux_in_valid),
            .in_ready  (mux_in_ready),     .out_beat  (mux_out_beat),
            .out_valid (mux_out_valid),    .out_ready (mux_out_ready),
            .pkt_event (pkt_event[p])
        );

        // Registered ready toward the mux
        axis_skid_stage u_out_skid (
            .core_clk, .rst_n,
            .in_beat   (mux_out_beat),     .in_valid  (mux_out_valid),
            .in_ready  (mux_out_ready),    .out_beat  (out_beat[p]),
            .out_valid (out_valid[p]),     .out_ready (out_ready[p])
        );
    end

    // Mode bits and packet counters
    egr_reg_blk #(.NUM_PORTS(NUM_PORTS)) u_reg_blk (
        .core_clk, .rst_n,
        .reg_req, .reg_rsp,
        .pkt_event, .mode
    );

endmodule

// File: tb/smartnic_egr_asserts.sv
`timescale 1ns/10ps
`include "egr_params.svh"

module smartnic_egr_asserts #(
    parameter int NUM_PORTS = `EGR_NUM_PORTS
) (
    input logic                 core_clk,
    input logic                 rst_n,
    input egr_pkg::axis_beat_t  out_beat  [NUM_PORTS],
    input logic [NUM_PORTS-1:0] out_valid,
    input logic [NUM_PORTS-1:0] out_ready
);

    import egr_pkg::*;

    // First cycle out of reset, every egress port idle
    a_idle_after_reset: assert property (@(posedge core_clk) $rose(rst_n) |-> out_valid == '0)
        else $error("out_valid high in the first cycle after reset");

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // Stalled beat stays offered
        a_valid_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
            out_valid[p] && !out_ready[p] |=> out_valid[p])
            else $error("port %0d out_valid dropped before transfer", p);

        // Payload frozen while stalled
        a_beat_stable: assert property (@(posedge core_clk) disable iff (!rst_n)
            out_valid[p] && !out_ready[p] |=> $stable(out_beat[p]))
            else $error("port %0d out_beat changed while stalled", p);
    end

endmodule

bind smartnic_egr smartnic_egr_asserts #(.NUM_PORTS(NUM_PORTS)) u_asserts (.*);

// File: tb/smartnic_egr_tb.sv
`timescale 1ns/10ps
`include "egr_params.svh"

module smartnic_egr_tb;

    import egr_pkg::*;

    localparam int NP         = `EGR_NUM_PORTS;
    localparam int MAX_CYCLES = 4000;

    logic core_clk = 1'b0;
    logic rst_n    = 1'b0;
    axis_beat_t net_beat [NP];
    axis_beat_t h2c_beat [NP];
    axis_beat_t out_beat [NP];
    logic [NP-1:0] net_valid;
    logic [NP-1:0] net_ready;
    logic [NP-1:0] h2c_valid;
    logic [NP-1:0] h2c_ready;
    logic [NP-1:0] out_valid;
    logic [NP-1:0] out_ready;
    reg_req_t reg_req;
    reg_rsp_t reg_rsp;

    // Expected beats per port and source
    axis_beat_t exp_q [NP][2][$];
    int         src_log [NP][$];
    int         cnt_model [NP][2];
    logic       in_pkt [NP];
    int         cur_src [NP];
    logic [NP-1:0] rand_rdy = '0;

    string cur_test;
    int    err_cnt = 0;
    int    test_err0;
    int    tests_ok = 0;
    int    tests_bad = 0;
    int    cycles = 0;

    smartnic_egr u_smartnic_egr (.*);

    always #2 core_clk = ~core_clk;

    // ####################################################################
    // Timeout, random back-pressure, output monitor
    // ####################################################################

    always @(posedge core_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles in test %s", cycles, cur_test);
            $display("Verification failed");
            $finish;
        end
    end

    always @(negedge core_clk) begin
        for (int p = 0; p < NP; p++) begin
            out_ready[p] = rand_rdy[p] ? 1'($urandom % 2) : 1'b1;
        end
    end

    task automatic check_port(input int p);
        axis_beat_t exp_b;
        int s;
        if (!(rst_n && out_valid[p] && out_ready[p])) return;
        // Source taken from tid at packet start and held until tlast
        s = in_pkt[p] ? cur_src[p] : int'(out_beat[p].tid[0]);
        assert (exp_q[p][s].size() > 0) else begin
            $display("%s: port %0d sent a beat with no packet pending", cur_test, p);
            err_cnt++;
            return;
        end
        exp_b = exp_q[p][s].pop_front();
        assert (out_beat[p] == exp_b) else begin
            $display("[ERROR] %s: port %0d expected %h actual %h", cur_test, p, exp_b,
                     out_beat[p]);
            err_cnt++;
        end
        in_pkt[p]  = !out_beat[p].tlast;
        cur_src[p] = s;
        if (out_beat[p].tlast) begin
            src_log[p].push_back(s);
            cnt_model[p][s]++;
        end
    endtask

    always @(posedge core_clk) begin
        for (int p = 0; p < NP; p++) begin
            check_port(p);
        end
    end

    // ####################################################################
    // Stimulus helpers
    // ####################################################################

    function automatic axis_beat_t make_beat(input int p, input int s, input int i,
                                             input logic last);
        axis_beat_t b;
        b.tdata = {$urandom, $urandom};
        b.tkeep = last ? (8'hff >> ($urandom % 8)) : 8'hff;
        b.tlast = last;
        b.tid   = 4'(p * 2 + s);
        b.tdest = 4'(i);
        b.tuser = 8'($urandom);
        return b;
    endfunction

    task automatic send_packets(input int p, input int s, input int npkt, input int max_len);
        axis_beat_t b;
        int len;
        for (int k = 0; k < npkt; k++) begin
            len = 1 + ($urandom % max_len);
            for (int i = 0; i < len; i++) begin
                b = make_beat(p, s, i, i == len - 1);
                exp_q[p][s].push_back(b);
                @(negedge core_clk);
                if (s == 0) begin
                    net_beat[p]  = b;
                    net_valid[p] = 1'b1;
                end else begin
                    h2c_beat[p]  = b;
                    h2c_valid[p] = 1'b1;
                end
                #1;
                while (!(s == 0 ? net_ready[p] : h2c_ready[p])) begin
                    @(negedge core_clk);
                    #1;
                end
                @(posedge core_clk);
            end
        end
        @(negedge core_clk);
        if (s == 0) net_valid[p] = 1'b0;
        else h2c_valid[p] = 1'b0;
    endtask

    task automatic wait_drain();
        logic busy;
        do begin
            @(posedge core_clk);
            busy = 1'b0;
            for (int p = 0; p < NP; p++) begin
                busy |= in_pkt[p] || exp_q[p][0].size() > 0 || exp_q[p][1].size() > 0;
            end
        end while (busy);
        repeat (4) @(posedge core_clk);
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge core_clk);
        reg_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(negedge core_clk);
        reg_req = '0;
    endtask

    task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp_d);
        @(negedge core_clk);
        reg_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'd0};
        @(negedge core_clk);
        reg_req = '0;
        assert (reg_rsp.rvalid && reg_rsp.rdata == exp_d) else begin
            $display("[ERROR] %s: reg %h expected %h actual %h (rvalid %b)", cur_test, addr,
                     exp_d, reg_rsp.rdata, reg_rsp.rvalid);
            err_cnt++;
        end
    endtask

    // Split counts the network packets ahead of the host ones
    // A negative split asks for strict alternation
    task automatic check_order(input int p, input int first, input int split);
        for (int i = first; i < src_log[p].size(); i++) begin
            if (split < 0 && i > first) begin
                assert (src_log[p][i] != src_log[p][i-1]) else begin
                    $display("[ERROR] %s: port %0d pkt %0d expected src %0d actual %0d",
                             cur_test, p, i, 1 - src_log[p][i-1], src_log[p][i]);
                    err_cnt++;
                end
            end else if (split >= 0) begin
                assert (src_log[p][i] == int'(i - first >= split)) else begin
                    $display("[ERROR] %s: port %0d pkt %0d expected src %0d actual %0d",
                             cur_test, p, i, int'(i - first >= split), src_log[p][i]);
                    err_cnt++;
                end
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == test_err0) tests_ok++;
        else tests_bad++;
        $display("%-16s %s (%0d errors)", cur_test, err_cnt == test_err0 ? "ok" : "FAILED",
                 err_cnt - test_err0);
    endtask

    // ####################################################################
    // Directed tests
    // ####################################################################

    task automatic test_reset_latency();
        axis_beat_t b;
        begin_test("reset_latency");
        @(negedge core_clk);
        assert (out_valid == '0 && net_ready == '1 && h2c_ready == '1) else begin
            $display("[ERROR] %s: expected valid 0 ready 1 actual %b %b %b", cur_test,
                     out_valid, net_ready, h2c_ready);
            err_cnt++;
        end
        b = make_beat(0, 0, 0, 1'b1);
        exp_q[0][0].push_back(b);
        net_beat[0]  = b;
        net_valid[0] = 1'b1;
        @(posedge core_clk);
        @(negedge core_clk);
        net_valid[0] = 1'b0;
        assert (out_valid[0] == 1'b0) else begin
            $display("[ERROR] %s: cycle 1 expected valid 0 actual 1", cur_test);
            err_cnt++;
        end
        @(negedge core_clk);
        assert (out_valid[0] && out_beat[0] == b) else begin
            $display("[ERROR] %s: cycle 2 expected %h actual %h (valid %b)", cur_test, b,
                     out_beat[0], out_valid[0]);
            err_cnt++;
        end
        wait_drain();
        end_test();
    endtask

    task automatic test_h2c_backpressure();
        begin_test("h2c_backpressure");
        // Random stalls on port 1 only
        rand_rdy[1] = 1'b1;
        send_packets(1, 1, 10, 6);
        wait_drain();
        rand_rdy = '0;
        end_test();
    endtask

    task automatic test_traffic(input string name, input int mode_val, input int npkt,
                                input logic [NP-1:0] stall);
        int s0 [NP];
        begin_test(name);
        rand_rdy = stall;
        reg_write(`EGR_REG_CTRL, 32'(mode_val));
        for (int p = 0; p < NP; p++) s0[p] = src_log[p].size();
        fork
            send_packets(0, 0, npkt, 4);
            send_packets(0, 1, npkt, 4);
            send_packets(1, 0, npkt, 4);
            send_packets(1, 1, npkt, 4);
        join
        wait_drain();
        rand_rdy = '0;
        check_order(0, s0[0], mode_val[0] ? npkt : -1);
        check_order(1, s0[1], -1);
        end_test();
    endtask

    task automatic test_counters();
        begin_test("counters");
        for (int c = 0; c < 2 * NP; c++) begin
            reg_check(8'(`EGR_REG_CNT_BASE + 4 * c), 32'(cnt_model[c / 2][c % 2]));
            reg_write(8'(`EGR_REG_CNT_BASE + 4 * c), 32'hffff_ffff);
            cnt_model[c / 2][c % 2] = 0;
            reg_check(8'(`EGR_REG_CNT_BASE + 4 * c), 32'd0);
        end
        reg_check(8'h40, 32'd0);
        // Mode bits left by the strict test, then only NP bits kept
        reg_check(`EGR_REG_CTRL, 32'd1);
        reg_write(`EGR_REG_CTRL, 32'hffff_fffe);
        reg_check(`EGR_REG_CTRL, 32'hffff_fffe & ((32'd1 << NP) - 32'd1));
        end_test();
    endtask

    initial begin
        void'($urandom(32'ha55c8616));
        for (int p = 0; p < NP; p++) begin
            net_beat[p] = '0;
            h2c_beat[p] = '0;
            in_pkt[p]   = 1'b0;
            cur_src[p]  = 0;
            cnt_model[p][0] = 0;
            cnt_model[p][1] = 0;
        end
        net_valid = '0;
        h2c_valid = '0;
        out_ready = '1;
        reg_req   = '0;
        cur_test  = "reset";
        repeat (3) @(posedge core_clk);
        @(negedge core_clk);
        rst_n = 1'b1;

        test_reset_latency();
        test_h2c_backpressure();
        test_traffic("round_robin", 0, 6, '0);
        test_traffic("strict_priority", 1, 5, '0);
        test_counters();
        test_traffic("port_independence", 0, 6, '1);

        $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0 && tests_bad == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: smartnic_egr.f
+incdir+include
logic/egr_pkg.sv
logic/axis_stage.sv
logic/axis_skid_stage.sv
logic/axis_pkt_mux.sv
logic/egr_reg_blk.sv
logic/smartnic_egr.sv
tb/smartnic_egr_asserts.sv
tb/smartnic_egr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the egress testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f smartnic_egr.f \
    --top-module smartnic_egr_tb -o sim_egr > build.log 2>&1 \
    && ./obj_dir/sim_egr > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
